/* common/mem_route_pkg.sv */
package mem_route_pkg;

    // bus widths
    localparam int addr_w = 32;
    localparam int data_w = 32;
    localparam int strb_w = 4;
    localparam int size_w = 3;

    // top segment bits, cleared to form the physical address
    localparam int seg_w = 3;

    // page field of an address
    localparam int page_w = 16;

    // configuration register window, seen through kseg1 and as physical
    localparam logic [page_w-1:0] dev_page_hi = 16'hbfaf;
    localparam logic [page_w-1:0] dev_page_lo = 16'h1faf;

    // channel indices
    localparam int chan_inst = 0;
    localparam int chan_data = 1;
    localparam int num_chan = 2;

    // segment view
    typedef struct packed {
        logic [seg_w-1:0]        seg;
        logic [addr_w-seg_w-1:0] offset;
    } addr_seg_t;

    // page view
    typedef struct packed {
        logic [page_w-1:0]        page;
        logic [addr_w-page_w-1:0] index;
    } addr_page_t;

    // one address word, decoded either way
    typedef union packed {
        addr_seg_t  seg;
        addr_page_t page;
    } mem_addr_u;

endpackage

/* common/channel_if.sv */
`timescale 1ns/10ps

interface channel_if;
    import mem_route_pkg::*;

    // request side, from the classifier
    logic              req;
    logic              cached;
    logic [addr_w-1:0] phys_addr;

    // response side, from the tracker
    logic              addr_ok;
    logic              data_ok;
    logic [data_w-1:0] rdata;

    modport classifier (
        output req,
        output cached,
        output phys_addr,
        input  addr_ok,
        input  data_ok,
        input  rdata
    );

    modport tracker (
        input  req,
        input  cached,
        input  phys_addr,
        output addr_ok,
        output data_ok,
        output rdata
    );

endinterface

/* logic/access_classifier.sv */
`timescale 1ns/10ps

module access_classifier (
    // instruction channel, core side
    input  logic                                inst_req,
    input  logic                                inst_cache,
    input  mem_route_pkg::mem_addr_u            inst_addr,
    output logic                                inst_addr_ok,
    output logic                                inst_data_ok,
    output logic [mem_route_pkg::data_w-1:0]    inst_rdata,

    // data channel, core side
    input  logic                                data_req,
    input  logic                                data_cache,
    input  mem_route_pkg::mem_addr_u            data_addr,
    output logic                                data_addr_ok,
    output logic                                data_data_ok,
    output logic [mem_route_pkg::data_w-1:0]    data_rdata,

    // one bus per channel towards the trackers
    channel_if.classifier                       chan [mem_route_pkg::num_chan]
);
    import mem_route_pkg::*;

    logic dev_page;
    logic inst_cached;
    logic data_cached;

    // config registers must never be cached
    assign dev_page = (data_addr.page.page == dev_page_hi) ||
                      (data_addr.page.page == dev_page_lo);

    // attribute only taken while req is up, keeps an idle attribute off the mux
    assign inst_cached = inst_req & inst_cache;
    assign data_cached = data_req & data_cache & ~dev_page;

    // instruction fetch
    assign chan[chan_inst].req       = inst_req;
    assign chan[chan_inst].cached    = inst_cached;
    assign chan[chan_inst].phys_addr = {{seg_w{1'b0}}, inst_addr.seg.offset};

    // data access
    assign chan[chan_data].req       = data_req;
    assign chan[chan_data].cached    = data_cached;
    assign chan[chan_data].phys_addr = {{seg_w{1'b0}}, data_addr.seg.offset};

    // responses go straight back to the core
    assign inst_addr_ok = chan[chan_inst].addr_ok;
    assign inst_data_ok = chan[chan_inst].data_ok;
    assign inst_rdata   = chan[chan_inst].rdata;

    assign data_addr_ok = chan[chan_data].addr_ok;
    assign data_data_ok = chan[chan_data].data_ok;
    assign data_rdata   = chan[chan_data].rdata;

endmodule

/* route_tracker/route_tracker.sv */
`timescale 1ns/10ps

module route_tracker #(
    // power of two, at least 2
    parameter int queue_depth = 4
) (
    input  logic                                aclk,
    input  logic                                aresetn,

    // classified request from the core
    channel_if.tracker                          chan,

    // cached target
    output logic                                cache_req,
    input  logic                                cache_addr_ok,
    input  logic                                cache_data_ok,
    input  logic [mem_route_pkg::data_w-1:0]    cache_rdata,

    // uncached target
    output logic                                uncache_req,
    input  logic                                uncache_addr_ok,
    input  logic                                uncache_data_ok,
    input  logic [mem_route_pkg::data_w-1:0]    uncache_rdata,

    // acceptance strobes for the counters
    output logic                                accept,
    output logic                                accept_cached
);
    localparam int ptr_w = $clog2(queue_depth);

    // one source bit per outstanding request, 1 means cached
    logic [queue_depth-1:0] src_queue;
    logic [ptr_w-1:0]       wr_ptr;
    logic [ptr_w-1:0]       rd_ptr;
    logic [ptr_w:0]         pending;

    logic head_src;
    logic empty;
    logic full;
    logic allow;
    logic target_ok;
    logic done;

    assign empty    = (pending == '0);
    assign full     = (pending == queue_depth[ptr_w:0]);
    assign head_src = src_queue[rd_ptr];

    // never mix sources in flight, so returns stay in order
    assign allow = ~full & (empty | (chan.cached == head_src));

    // steering
    assign cache_req   = chan.req & allow & chan.cached;
    assign uncache_req = chan.req & allow & ~chan.cached;

    assign target_ok    = chan.cached ? cache_addr_ok : uncache_addr_ok;
    assign chan.addr_ok = allow & target_ok;

    assign accept        = chan.req & chan.addr_ok;
    assign accept_cached = accept & chan.cached;

    // returns taken from the source at the head only
    assign done         = ~empty & (head_src ? cache_data_ok : uncache_data_ok);
    assign chan.data_ok = done;
    assign chan.rdata   = head_src ? cache_rdata : uncache_rdata;

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            src_queue <= '0;
            wr_ptr    <= '0;
            rd_ptr    <= '0;
        end else begin
            if (accept) begin
                src_queue[wr_ptr] <= chan.cached;
                wr_ptr            <= wr_ptr + 1'b1;
            end
            if (done) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    // occupancy, unchanged when one enters and one leaves
    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            pending <= '0;
        end else begin
            case ({accept, done})
                2'b10: pending <= pending + 1'b1;
                2'b01: pending <= pending - 1'b1;
                default: pending <= pending;
            endcase
        end
    end

endmodule

/* logic/traffic_counter.sv */
`timescale 1ns/10ps

module traffic_counter #(
    parameter int count_w = 32
) (
    input  logic                                 aclk,
    input  logic                                 aresetn,

    // per channel acceptance strobes
    input  logic [mem_route_pkg::num_chan-1:0]   accept,
    input  logic [mem_route_pkg::num_chan-1:0]   accept_cached,
    input  logic                                 data_wr,

    // data channel, by source and direction
    output logic [count_w-1:0]                   cache_r_count,
    output logic [count_w-1:0]                   cache_w_count,
    output logic [count_w-1:0]                   uncache_r_count,
    output logic [count_w-1:0]                   uncache_w_count,

    // instruction channel, by source
    output logic [count_w-1:0]                   inst_cache_count,
    output logic [count_w-1:0]                   inst_uncache_count
);
    import mem_route_pkg::*;

    logic data_c;
    logic data_u;
    logic inst_c;
    logic inst_u;

    assign data_c = accept[chan_data] & accept_cached[chan_data];
    assign data_u = accept[chan_data] & ~accept_cached[chan_data];
    assign inst_c = accept[chan_inst] & accept_cached[chan_inst];
    assign inst_u = accept[chan_inst] & ~accept_cached[chan_inst];

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            cache_r_count      <= '0;
            cache_w_count      <= '0;
            uncache_r_count    <= '0;
            uncache_w_count    <= '0;
            inst_cache_count   <= '0;
            inst_uncache_count <= '0;
        end else begin
            if (data_c & ~data_wr) cache_r_count <= cache_r_count + 1'b1;
            if (data_c & data_wr) cache_w_count <= cache_w_count + 1'b1;
            if (data_u & ~data_wr) uncache_r_count <= uncache_r_count + 1'b1;
            if (data_u & data_wr) uncache_w_count <= uncache_w_count + 1'b1;
            // fetches are reads only
            if (inst_c) inst_cache_count <= inst_cache_count + 1'b1;
            if (inst_u) inst_uncache_count <= inst_uncache_count + 1'b1;
        end
    end

endmodule

/* logic/mem_route_top.sv */
`timescale 1ns/10ps

module mem_route_top #(
    parameter int queue_depth = 4,
    parameter int count_w     = 32
) (
    input  logic                                aclk,
    input  logic                                aresetn,

    // core instruction channel
    input  logic                                inst_req,
    input  logic                                inst_cache,
    input  logic [mem_route_pkg::addr_w-1:0]    inst_addr,
    output logic [mem_route_pkg::data_w-1:0]    inst_rdata,
    output logic                                inst_addr_ok,
    output logic                                inst_data_ok,

    // core data channel
    input  logic                                data_req,
    input  logic                                data_cache,
    input  logic                                data_wr,
    input  logic [mem_route_pkg::size_w-1:0]    data_size,
    input  logic [mem_route_pkg::strb_w-1:0]    data_wstrb,
    input  logic [mem_route_pkg::addr_w-1:0]    data_addr,
    input  logic [mem_route_pkg::data_w-1:0]    data_wdata,
    output logic [mem_route_pkg::data_w-1:0]    data_rdata,
    output logic                                data_addr_ok,
    output logic                                data_data_ok,

    // cached fetch target
    output logic                                icache_req,
    output logic [mem_route_pkg::addr_w-1:0]    icache_addr,
    input  logic                                icache_addr_ok,
    input  logic                                icache_data_ok,
    input  logic [mem_route_pkg::data_w-1:0]    icache_rdata,

    // uncached fetch target
    output logic                                iuncache_req,
    output logic [mem_route_pkg::addr_w-1:0]    iuncache_addr,
    input  logic                                iuncache_addr_ok,
    input  logic                                iuncache_data_ok,
    input  logic [mem_route_pkg::data_w-1:0]    iuncache_rdata,

    // cached data target
    output logic                                dcache_req,
    output logic                                dcache_wr,
    output logic [mem_route_pkg::size_w-1:0]    dcache_size,
    output logic [mem_route_pkg::strb_w-1:0]    dcache_wstrb,
    output logic [mem_route_pkg::addr_w-1:0]    dcache_addr,
    output logic [mem_route_pkg::data_w-1:0]    dcache_wdata,
    input  logic                                dcache_addr_ok,
    input  logic                                dcache_data_ok,
    input  logic [mem_route_pkg::data_w-1:0]    dcache_rdata,

    // uncached data target
    output logic                                duncache_req,
    output logic                                duncache_wr,
    output logic [mem_route_pkg::size_w-1:0]    duncache_size,
    output logic [mem_route_pkg::strb_w-1:0]    duncache_wstrb,
    output logic [mem_route_pkg::addr_w-1:0]    duncache_addr,
    output logic [mem_route_pkg::data_w-1:0]    duncache_wdata,
    input  logic                                duncache_addr_ok,
    input  logic                                duncache_data_ok,
    input  logic [mem_route_pkg::data_w-1:0]    duncache_rdata,

    // traffic counts
    output logic [count_w-1:0]                  cache_r_count,
    output logic [count_w-1:0]                  cache_w_count,
    output logic [count_w-1:0]                  uncache_r_count,
    output logic [count_w-1:0]                  uncache_w_count,
    output logic [count_w-1:0]                  inst_cache_count,
    output logic [count_w-1:0]                  inst_uncache_count
);
    import mem_route_pkg::*;

    channel_if chan_bus [num_chan] ();

    // per channel target wires, indexed by chan_inst / chan_data
    logic [num_chan-1:0] cache_req_w;
    logic [num_chan-1:0] uncache_req_w;
    logic [num_chan-1:0] cache_addr_ok_w;
    logic [num_chan-1:0] uncache_addr_ok_w;
    logic [num_chan-1:0] cache_data_ok_w;
    logic [num_chan-1:0] uncache_data_ok_w;
    logic [data_w-1:0]   cache_rdata_w [num_chan];
    logic [data_w-1:0]   uncache_rdata_w [num_chan];
    logic [num_chan-1:0] accept_w;
    logic [num_chan-1:0] accept_cached_w;

    access_classifier u_classifier (
        .inst_req     (inst_req),
        .inst_cache   (inst_cache),
        .inst_addr    (inst_addr),
        .inst_addr_ok (inst_addr_ok),
        .inst_data_ok (inst_data_ok),
        .inst_rdata   (inst_rdata),
        .data_req     (data_req),
        .data_cache   (data_cache),
        .data_addr    (data_addr),
        .data_addr_ok (data_addr_ok),
        .data_data_ok (data_data_ok),
        .data_rdata   (data_rdata),
        .chan         (chan_bus)
    );

    for (genvar g = 0; g < num_chan; g++) begin : g_track
        route_tracker #(
            .queue_depth (queue_depth)
        ) u_tracker (
            .aclk            (aclk),
            .aresetn         (aresetn),
            .chan            (chan_bus[g]),
            .cache_req       (cache_req_w[g]),
            .cache_addr_ok   (cache_addr_ok_w[g]),
            .cache_data_ok   (cache_data_ok_w[g]),
            .cache_rdata     (cache_rdata_w[g]),
            .uncache_req     (uncache_req_w[g]),
            .uncache_addr_ok (uncache_addr_ok_w[g]),
            .uncache_data_ok (uncache_data_ok_w[g]),
            .uncache_rdata   (uncache_rdata_w[g]),
            .accept          (accept_w[g]),
            .accept_cached   (accept_cached_w[g])
        );
    end

    traffic_counter #(
        .count_w (count_w)
    ) u_counter (
        .aclk               (aclk),
        .aresetn            (aresetn),
        .accept             (accept_w),
        .accept_cached      (accept_cached_w),
        .data_wr            (data_wr),
        .cache_r_count      (cache_r_count),
        .cache_w_count      (cache_w_count),
        .uncache_r_count    (uncache_r_count),
        .uncache_w_count    (uncache_w_count),
        .inst_cache_count   (inst_cache_count),
        .inst_uncache_count (inst_uncache_count)
    );

    // fetch targets
    assign icache_req                     = cache_req_w[chan_inst];
    assign icache_addr                    = chan_bus[chan_inst].phys_addr;
    assign cache_addr_ok_w[chan_inst]     = icache_addr_ok;
    assign cache_data_ok_w[chan_inst]     = icache_data_ok;
    assign cache_rdata_w[chan_inst]       = icache_rdata;

    assign iuncache_req                   = uncache_req_w[chan_inst];
    assign iuncache_addr                  = chan_bus[chan_inst].phys_addr;
    assign uncache_addr_ok_w[chan_inst]   = iuncache_addr_ok;
    assign uncache_data_ok_w[chan_inst]   = iuncache_data_ok;
    assign uncache_rdata_w[chan_inst]     = iuncache_rdata;

    // data targets
    assign dcache_req                     = cache_req_w[chan_data];
    assign dcache_addr                    = chan_bus[chan_data].phys_addr;
    assign cache_addr_ok_w[chan_data]     = dcache_addr_ok;
    assign cache_data_ok_w[chan_data]     = dcache_data_ok;
    assign cache_rdata_w[chan_data]       = dcache_rdata;

    assign duncache_req                   = uncache_req_w[chan_data];
    assign duncache_addr                  = chan_bus[chan_data].phys_addr;
    assign uncache_addr_ok_w[chan_data]   = duncache_addr_ok;
    assign uncache_data_ok_w[chan_data]   = duncache_data_ok;
    assign uncache_rdata_w[chan_data]     = duncache_rdata;

    // write payload passes straight from the core
    assign dcache_wr      = data_wr;
    assign dcache_size    = data_size;
    assign dcache_wstrb   = data_wstrb;
    assign dcache_wdata   = data_wdata;
    assign duncache_wr    = data_wr;
    assign duncache_size  = data_size;
    assign duncache_wstrb = data_wstrb;
    assign duncache_wdata = data_wdata;

endmodule

/* testbench/route_checker.sv */
`timescale 1ns/10ps

module route_checker #(
    parameter int          queue_depth  = 4,
    parameter logic [31:0] icache_tag   = '0,
    parameter logic [31:0] iuncache_tag = '0,
    parameter logic [31:0] dcache_tag   = '0,
    parameter logic [31:0] duncache_tag = '0
) (
    input logic        aclk,
    input logic        aresetn,
    input logic        inst_req, inst_cache, inst_addr_ok, inst_data_ok,
    input logic [31:0] inst_addr, inst_rdata,
    input logic        data_req, data_cache, data_wr, data_addr_ok, data_data_ok,
    input logic [31:0] data_addr, data_rdata,
    input logic [2:0]  data_size, dcache_size, duncache_size,
    input logic [3:0]  data_wstrb, dcache_wstrb, duncache_wstrb,
    input logic [31:0] data_wdata, dcache_wdata, duncache_wdata,
    input logic        dcache_wr, duncache_wr,
    input logic        icache_req, icache_addr_ok, iuncache_req, iuncache_addr_ok,
    input logic        dcache_req, dcache_addr_ok, duncache_req, duncache_addr_ok,
    input logic [31:0] icache_addr, iuncache_addr, dcache_addr, duncache_addr,
    input logic [31:0] cache_r_count, cache_w_count, uncache_r_count, uncache_w_count,
    input logic [31:0] inst_cache_count, inst_uncache_count
);
    import mem_route_pkg::*;

    localparam int ring = 64;

    // expected return data and source per outstanding request
    logic [31:0] exp_data [num_chan][ring];
    logic        exp_src [num_chan][ring];
    int          head [num_chan];
    int          tail [num_chan];
    // cached r/w, uncached r/w, fetch cached, fetch uncached
    int          model_count [6];
    int          error_count = 0;

    task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) begin
            error_count++;
            $display("** Error: %s at %0t expected %h actual %h", name, $time, exp, act);
        end
    endtask

    task automatic report(input string msg);
        error_count++;
        $display("%0t: %s", $time, msg);
    endtask

    // write payload on a data target follows the core as it is
    task automatic compare_payload(input logic t_wr, input logic [2:0] t_size,
                                   input logic [3:0] t_wstrb, input logic [31:0] t_wdata);
        check_val("write flag", data_wr, t_wr);
        check_val("access size", data_size, t_size);
        check_val("write strobe", data_wstrb, t_wstrb);
        check_val("write data", data_wdata, t_wdata);
    endtask

    task automatic watch(input int ch, input logic req, input logic cache,
                         input logic [31:0] addr, input logic wr, input logic addr_ok,
                         input logic data_ok, input logic [31:0] rdata,
                         input logic c_req, input logic [31:0] c_addr, input logic c_ok,
                         input logic u_req, input logic [31:0] u_addr, input logic u_ok);
        logic [31:0] phys;
        logic        dev;
        logic        cached;
        logic        allow;
        int          outs;
        string       name;

        phys   = addr & 32'h1fff_ffff;
        dev    = (ch == chan_data) && (addr[31:16] == 16'hbfaf || addr[31:16] == 16'h1faf);
        cached = req && cache && !dev;
        name   = dev ? "device page" : "steering";
        outs   = tail[ch] - head[ch];
        // only one source in flight, and never past the queue depth
        allow  = (outs < queue_depth) && (outs == 0 || exp_src[ch][head[ch] % ring] == cached);
        check_val(name, req && allow && cached, c_req);
        check_val(name, req && allow && !cached, u_req);
        if (req && allow) begin
            check_val("target address", phys, cached ? c_addr : u_addr);
        end
        check_val("stall", allow && (cached ? c_ok : u_ok), addr_ok);
        if (data_ok) begin
            if (outs == 0) begin
                report("data_ok returned with no request outstanding");
            end else begin
                check_val("ordering", exp_data[ch][head[ch] % ring], rdata);
                head[ch]++;
            end
        end
        if (req && addr_ok) begin
            exp_src[ch][tail[ch] % ring] = cached;
            if (ch == chan_inst) begin
                exp_data[ch][tail[ch] % ring] = phys ^ (cached ? icache_tag : iuncache_tag);
                model_count[cached ? 4 : 5]++;
            end else begin
                exp_data[ch][tail[ch] % ring] = phys ^ (cached ? dcache_tag : duncache_tag);
                model_count[{!cached, wr}]++;
            end
            tail[ch]++;
            if (tail[ch] - head[ch] > queue_depth) begin
                report("more requests outstanding than the queue depth");
            end
        end
    endtask

    always @(posedge aclk) begin
        if (aresetn) begin
            watch(chan_inst, inst_req, inst_cache, inst_addr, 1'b0, inst_addr_ok,
                  inst_data_ok, inst_rdata, icache_req, icache_addr, icache_addr_ok,
                  iuncache_req, iuncache_addr, iuncache_addr_ok);
            watch(chan_data, data_req, data_cache, data_addr, data_wr, data_addr_ok,
                  data_data_ok, data_rdata, dcache_req, dcache_addr, dcache_addr_ok,
                  duncache_req, duncache_addr, duncache_addr_ok);
            if (dcache_req) begin
                compare_payload(dcache_wr, dcache_size, dcache_wstrb, dcache_wdata);
            end
            if (duncache_req) begin
                compare_payload(duncache_wr, duncache_size, duncache_wstrb, duncache_wdata);
            end
        end
    end

    // counts must read zero one cycle after release
    initial begin
        int guard;
        guard = 0;
        while (aresetn !== 1'b1 && guard < 50) begin
            @(posedge aclk);
            guard++;
        end
        if (aresetn !== 1'b1) begin
            report("reset was never released");
        end else begin
            @(posedge aclk);
            check_val("reset", 32'd0, cache_r_count | cache_w_count | uncache_r_count |
                      uncache_w_count | inst_cache_count | inst_uncache_count);
        end
    end

    function automatic logic idle();
        return (head[chan_inst] == tail[chan_inst]) && (head[chan_data] == tail[chan_data]);
    endfunction

    task automatic check_counts();
        check_val("cached read count", model_count[0], cache_r_count);
        check_val("cached write count", model_count[1], cache_w_count);
        check_val("uncached read count", model_count[2], uncache_r_count);
        check_val("uncached write count", model_count[3], uncache_w_count);
        check_val("cached fetch count", model_count[4], inst_cache_count);
        check_val("uncached fetch count", model_count[5], inst_uncache_count);
    endtask
endmodule

/* testbench/tb_mem_route.sv */
`timescale 1ns/10ps

// in-order target, answers each request with tag ^ addr after a random delay
module target_responder #(
    parameter logic [31:0] tag       = '0,
    parameter int          seed_init = 56
) (
    input  logic        aclk,
    input  logic        req,
    input  logic [31:0] addr,
    output logic        addr_ok,
    output logic        data_ok,
    output logic [31:0] rdata
);
    integer      seed = seed_init;
    int          delay = 0;
    logic [31:0] pend_q [$];

    initial begin
        addr_ok = 1'b0;
        data_ok = 1'b0;
        rdata   = '0;
    end

    always @(posedge aclk) begin
        if (req && addr_ok) begin
            pend_q.push_back(addr);
        end
    end

    // one pop per data_ok pulse
    always @(negedge aclk) begin
        addr_ok = ({$random(seed)} % 4) != 0;
        data_ok = 1'b0;
        if (pend_q.size() > 0) begin
            if (delay == 0) begin
                data_ok = 1'b1;
                rdata   = tag ^ pend_q.pop_front();
                delay   = {$random(seed)} % 5;
            end else begin
                delay = delay - 1;
            end
        end
    end
endmodule

module tb_mem_route;
    localparam int          n_req        = 300;
    localparam int          queue_depth  = 4;
    localparam int          base_seed    = 56;
    localparam logic [31:0] icache_tag   = 32'h2000_0000;
    localparam logic [31:0] iuncache_tag = 32'h4000_0000;
    localparam logic [31:0] dcache_tag   = 32'h6000_0000;
    localparam logic [31:0] duncache_tag = 32'h8000_0000;

    logic        aclk;
    logic        aresetn;
    logic        inst_req, inst_cache, inst_addr_ok, inst_data_ok;
    logic [31:0] inst_addr, inst_rdata;
    logic        data_req, data_cache, data_wr, data_addr_ok, data_data_ok;
    logic [2:0]  data_size;
    logic [3:0]  data_wstrb;
    logic [31:0] data_addr, data_wdata, data_rdata;
    logic        icache_req, icache_addr_ok, icache_data_ok;
    logic        iuncache_req, iuncache_addr_ok, iuncache_data_ok;
    logic [31:0] icache_addr, icache_rdata, iuncache_addr, iuncache_rdata;
    logic        dcache_req, dcache_wr, dcache_addr_ok, dcache_data_ok;
    logic        duncache_req, duncache_wr, duncache_addr_ok, duncache_data_ok;
    logic [2:0]  dcache_size, duncache_size;
    logic [3:0]  dcache_wstrb, duncache_wstrb;
    logic [31:0] dcache_addr, dcache_wdata, dcache_rdata;
    logic [31:0] duncache_addr, duncache_wdata, duncache_rdata;
    logic [31:0] cache_r_count, cache_w_count, uncache_r_count, uncache_w_count;
    logic [31:0] inst_cache_count, inst_uncache_count;

    integer      seed;
    int          timeouts;
    int          guard;
    logic [31:0] inst_addr_a [n_req];
    logic        inst_cache_a [n_req];
    logic [31:0] data_addr_a [n_req];
    logic        data_cache_a [n_req];
    logic        data_wr_a [n_req];
    logic [2:0]  data_size_a [n_req];
    logic [3:0]  data_wstrb_a [n_req];

    mem_route_top #(.queue_depth(queue_depth)) u_dut (.*);

    route_checker #(
        .queue_depth  (queue_depth),
        .icache_tag   (icache_tag),
        .iuncache_tag (iuncache_tag),
        .dcache_tag   (dcache_tag),
        .duncache_tag (duncache_tag)
    ) u_checker (.*);

    target_responder #(.tag(icache_tag), .seed_init(base_seed + 1)) u_icache (
        .aclk(aclk), .req(icache_req), .addr(icache_addr),
        .addr_ok(icache_addr_ok), .data_ok(icache_data_ok), .rdata(icache_rdata)
    );
    target_responder #(.tag(iuncache_tag), .seed_init(base_seed + 2)) u_iuncache (
        .aclk(aclk), .req(iuncache_req), .addr(iuncache_addr),
        .addr_ok(iuncache_addr_ok), .data_ok(iuncache_data_ok), .rdata(iuncache_rdata)
    );
    target_responder #(.tag(dcache_tag), .seed_init(base_seed + 3)) u_dcache (
        .aclk(aclk), .req(dcache_req), .addr(dcache_addr),
        .addr_ok(dcache_addr_ok), .data_ok(dcache_data_ok), .rdata(dcache_rdata)
    );
    target_responder #(.tag(duncache_tag), .seed_init(base_seed + 4)) u_duncache (
        .aclk(aclk), .req(duncache_req), .addr(duncache_addr),
        .addr_ok(duncache_addr_ok), .data_ok(duncache_data_ok), .rdata(duncache_rdata)
    );

    always #5 aclk = ~aclk;

    // roughly one in eight addresses lands in the device page
    function automatic logic [31:0] make_addr(input logic [31:0] r1, input logic [31:0] r2);
        if (r1[2:0] == 3'd0) begin
            return {(r1[3] ? 16'hbfaf : 16'h1faf), r2[15:2], 2'b00};
        end
        return {r2[31:2], 2'b00};
    endfunction

    task automatic run_inst();
        int wait_cnt;
        for (int i = 0; i < n_req; i++) begin
            inst_req = 1'b0;
            // spare address bits double as the idle gap
            repeat (inst_addr_a[i][4:3]) @(negedge aclk);
            inst_req   = 1'b1;
            inst_cache = inst_cache_a[i];
            inst_addr  = inst_addr_a[i];
            wait_cnt   = 0;
            do begin
                @(posedge aclk);
                wait_cnt++;
            end while (!inst_addr_ok && wait_cnt < 200);
            if (!inst_addr_ok) begin
                timeouts++;
                $display("fetch request %0d was never accepted", i);
            end
            @(negedge aclk);
        end
        inst_req = 1'b0;
    endtask

    task automatic run_data();
        int wait_cnt;
        for (int i = 0; i < n_req; i++) begin
            data_req = 1'b0;
            repeat (data_addr_a[i][4:3]) @(negedge aclk);
            data_req   = 1'b1;
            data_cache = data_cache_a[i];
            data_wr    = data_wr_a[i];
            data_size  = data_size_a[i];
            data_wstrb = data_wstrb_a[i];
            data_addr  = data_addr_a[i];
            data_wdata = ~data_addr_a[i];
            wait_cnt   = 0;
            do begin
                @(posedge aclk);
                wait_cnt++;
            end while (!data_addr_ok && wait_cnt < 200);
            if (!data_addr_ok) begin
                timeouts++;
                $display("data request %0d was never accepted", i);
            end
            @(negedge aclk);
        end
        data_req = 1'b0;
    endtask

    initial begin
        aclk       = 1'b0;
        aresetn    = 1'b0;
        inst_req   = 1'b0;
        inst_cache = 1'b0;
        inst_addr  = '0;
        data_req   = 1'b0;
        data_cache = 1'b0;
        data_wr    = 1'b0;
        data_size  = 3'd2;
        data_wstrb = 4'hf;
        data_addr  = '0;
        data_wdata = '0;
        timeouts   = 0;
        seed       = base_seed;
        for (int i = 0; i < n_req; i++) begin
            inst_addr_a[i]  = make_addr($random(seed), $random(seed));
            inst_cache_a[i] = $random(seed);
            data_addr_a[i]  = make_addr($random(seed), $random(seed));
            data_cache_a[i] = $random(seed);
            data_wr_a[i]    = $random(seed);
            data_size_a[i]  = $random(seed);
            data_wstrb_a[i] = $random(seed);
        end
        repeat (3) @(posedge aclk);
        @(negedge aclk);
        aresetn = 1'b1;
        repeat (2) @(negedge aclk);
        fork
            run_inst();
            run_data();
        join
        guard = 0;
        while (!u_checker.idle() && guard < 1000) begin
            @(posedge aclk);
            guard++;
        end
        if (!u_checker.idle()) begin
            timeouts++;
            $display("requests still outstanding when the drain wait ran out");
        end
        repeat (2) @(posedge aclk);
        u_checker.check_counts();
        $display("errors %0d, timeouts %0d", u_checker.error_count, timeouts);
        if (u_checker.error_count == 0 && timeouts == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end
endmodule

/* vlog.f */
common/mem_route_pkg.sv
common/channel_if.sv
logic/access_classifier.sv
route_tracker/route_tracker.sv
logic/traffic_counter.sv
logic/mem_route_top.sv
testbench/route_checker.sv
testbench/tb_mem_route.sv

/* Bender.yml */
package:
  name: mem_route

sources:
  - files:
      - common/mem_route_pkg.sv
      - common/channel_if.sv
      - logic/access_classifier.sv
      - route_tracker/route_tracker.sv
      - logic/traffic_counter.sv
      - logic/mem_route_top.sv
  - target: test
    files:
      - testbench/route_checker.sv
      - testbench/tb_mem_route.sv
